// File: div_unit.f
+incdir+sim
hdl/div_pkg.sv
hdl/div_precheck.sv
hdl/div_iter_core.sv
hdl/div_result_fix.sv
hdl/div_ctrl.sv
hdl/div_unit.sv
sim/tb_div_unit.sv

// File: hdl/div_ctrl.sv
// divide control FSM and response credits
`timescale 1ns/10ps
`default_nettype none

module div_ctrl
  import div_pkg::*;
#(
  parameter int unsigned RSP_CREDITS = 2
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic req_valid_i,
  input  wire logic exc_i,
  input  wire logic done_i,
  input  wire logic credit_i,
  output logic      load_o,
  output logic      exc_load_o,
  output logic      step_o,
  output logic      capture_o,
  output logic      busy_o,
  output logic      rsp_valid_o
);

  div_state_t state_q;
  div_state_t state_d;
  credit_t    credit_q;
  logic       accept;

  // ==========================================================================
  // state machine
  // ==========================================================================
  assign accept      = (state_q == IDLE) && req_valid_i;
  assign load_o      = accept && !exc_i;
  assign exc_load_o  = accept && exc_i;
  assign step_o      = (state_q == ITERATE);
  assign capture_o   = (state_q == FINISH);
  assign busy_o      = (state_q != IDLE);
  assign rsp_valid_o = (state_q == ISSUE) && (credit_q != '0);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_valid_i) begin
          state_d = exc_i ? ISSUE : ITERATE;   // special cases skip the loop
        end
      end
      ITERATE: begin
        if (done_i) begin
          state_d = FINISH;
        end
      end
      FINISH:  state_d = ISSUE;
      ISSUE: begin
        if (rsp_valid_o) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ==========================================================================
  // response credits
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      credit_q <= credit_t'(RSP_CREDITS);
    end else begin
      case ({credit_i, rsp_valid_o})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;   // none, or return and spend together
      endcase
    end
  end

  // core must hold off while busy
  a_no_req_while_busy: assert property (
    @(posedge clk) disable iff (rst_n)
    busy_o |-> !req_valid_i
  );

  // consumer never returns more slots than it has
  a_credit_bound: assert property (
    @(posedge clk) disable iff (rst_n)
    credit_q <= credit_t'(RSP_CREDITS)
  );

endmodule

`default_nettype wire

// File: hdl/div_iter_core.sv
// restoring divide iterator
`timescale 1ns/10ps
`default_nettype none

module div_iter_core
  import div_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  load_i,
  input  wire logic  step_i,
  input  wire logic  is_word_i,
  input  wire xlen_t dividend_i,
  input  wire xlen_t divisor_i,
  output xlen_t      quot_o,
  output xlen_t      rem_o,
  output logic       done_o
);

  dword_t      acc_q;      // {partial remainder, dividend / quotient bits}
  xlen_t       divisor_q;
  iter_cnt_t   cnt_q;
  logic [64:0] diff;       // shifted remainder minus divisor, msb is borrow

  // shifted-out bit joins the upper half, so compare on 65 bits
  assign diff = acc_q[127:63] - {1'b0, divisor_q};

  // ==========================================================================
  // shift / subtract datapath
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (load_i) begin
      acc_q     <= {64'b0, dividend_i};
      divisor_q <= divisor_i;
    end else if (step_i) begin
      if (diff[64]) begin
        acc_q <= {acc_q[126:0], 1'b0};              // restore, q bit 0
      end else begin
        acc_q <= {diff[63:0], acc_q[62:0], 1'b1};   // keep difference, q bit 1
      end
    end
  end

  // remaining step count
  always_ff @(posedge clk) begin
    if (rst_n) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= is_word_i ? ITER_W : ITER_D;
    end else if (step_i) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // high on the last step so the FSM leaves ITERATE right after it
  assign done_o = (cnt_q <= iter_cnt_t'(1));
  assign quot_o = acc_q[63:0];
  assign rem_o  = acc_q[127:64];

  // controller must stop stepping once the count is spent
  a_no_step_after_done: assert property (
    @(posedge clk) disable iff (rst_n)
    (cnt_q == '0) |-> !step_i
  );

endmodule

`default_nettype wire

// File: hdl/div_pkg.sv
// divide unit shared types
`default_nettype none

package div_pkg;

  // ==========================================================================
  // data widths
  // ==========================================================================
  typedef logic [63:0]  xlen_t;      // operand / result word
  typedef logic [127:0] dword_t;     // {remainder, quotient} shift register
  typedef logic [7:0]   div_op_t;    // one-hot operation code
  typedef logic [6:0]   iter_cnt_t;  // 0..64 remaining steps
  typedef logic [3:0]   credit_t;    // response credits

  // one-hot encodings, msb first
  localparam div_op_t OP_DIV   = 8'b1000_0000;
  localparam div_op_t OP_DIVU  = 8'b0100_0000;
  localparam div_op_t OP_DIVUW = 8'b0010_0000;
  localparam div_op_t OP_DIVW  = 8'b0001_0000;
  localparam div_op_t OP_REM   = 8'b0000_1000;
  localparam div_op_t OP_REMU  = 8'b0000_0100;
  localparam div_op_t OP_REMUW = 8'b0000_0010;
  localparam div_op_t OP_REMW  = 8'b0000_0001;

  // operation class masks
  localparam div_op_t OP_SIGNED_M = OP_DIV | OP_DIVW | OP_REM | OP_REMW;
  localparam div_op_t OP_WORD_M   = OP_DIVUW | OP_DIVW | OP_REMUW | OP_REMW;
  localparam div_op_t OP_REM_M    = OP_REM | OP_REMU | OP_REMUW | OP_REMW;

  // iteration counts
  localparam iter_cnt_t ITER_D = 7'd64;
  localparam iter_cnt_t ITER_W = 7'd32;

  typedef enum logic [1:0] {
    IDLE,
    ITERATE,
    FINISH,
    ISSUE
  } div_state_t;

endpackage

`default_nettype wire

// File: hdl/div_precheck.sv
// divide operand precheck
`timescale 1ns/10ps
`default_nettype none

module div_precheck
  import div_pkg::*;
(
  input  wire div_op_t op_i,
  input  wire xlen_t   a_i,
  input  wire xlen_t   b_i,
  output xlen_t        mag_a_o,
  output xlen_t        mag_b_o,
  output logic         neg_q_o,
  output logic         neg_r_o,
  output logic         is_word_o,
  output logic         exc_o,
  output xlen_t        exc_value_o
);

  logic  is_signed;
  logic  is_word;
  logic  is_rem;
  xlen_t a_sext;
  xlen_t b_sext;
  xlen_t a_ext;
  xlen_t b_ext;
  xlen_t mag_a;
  xlen_t mag_b;
  xlen_t a_arch;                 // dividend as the architecture returns it
  logic  a_neg;
  logic  b_neg;
  logic  b_zero;
  logic  ovf;

  // ==========================================================================
  // operation decode
  // ==========================================================================
  assign is_signed = |(op_i & OP_SIGNED_M);
  assign is_word   = |(op_i & OP_WORD_M);
  assign is_rem    = |(op_i & OP_REM_M);
  assign is_word_o = is_word;

  // word ops only look at the low half
  assign a_sext = {{32{a_i[31]}}, a_i[31:0]};
  assign b_sext = {{32{b_i[31]}}, b_i[31:0]};
  assign a_ext  = is_word ? (is_signed ? a_sext : {32'b0, a_i[31:0]}) : a_i;
  assign b_ext  = is_word ? (is_signed ? b_sext : {32'b0, b_i[31:0]}) : b_i;

  // magnitudes
  assign a_neg = is_signed & a_ext[63];
  assign b_neg = is_signed & b_ext[63];
  assign mag_a = a_neg ? (~a_ext + 64'd1) : a_ext;
  assign mag_b = b_neg ? (~b_ext + 64'd1) : b_ext;

  // word dividend sits in the top half so 32 shifts bring it down
  assign mag_a_o = is_word ? {mag_a[31:0], 32'b0} : mag_a;
  assign mag_b_o = mag_b;    // word divisor magnitude fits in the low 32 bits

  assign neg_q_o = a_neg ^ b_neg;
  assign neg_r_o = a_neg;    // remainder follows the dividend

  // ==========================================================================
  // special cases
  // ==========================================================================
  assign b_zero = is_word ? (b_i[31:0] == 32'b0) : (b_i == 64'b0);

  // most negative by minus one
  assign ovf = is_signed & (is_word ?
                 (a_i[31:0] == 32'h8000_0000) && (&b_i[31:0]) :
                 (a_i == {1'b1, 63'b0}) && (&b_i));

  assign exc_o  = b_zero | ovf;
  assign a_arch = is_word ? a_sext : a_i;

  always_comb begin
    exc_value_o = '0;
    if (b_zero) begin
      exc_value_o = is_rem ? a_arch : '1;
    end else if (ovf) begin
      exc_value_o = is_rem ? '0 : a_arch;
    end
  end

endmodule

`default_nettype wire

// File: hdl/div_result_fix.sv
// divide result fixup
`timescale 1ns/10ps
`default_nettype none

module div_result_fix
  import div_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    rst_n,
  input  wire logic    load_i,
  input  wire logic    exc_load_i,
  input  wire logic    capture_i,
  input  wire div_op_t op_i,
  input  wire logic    neg_q_i,
  input  wire logic    neg_r_i,
  input  wire xlen_t   exc_value_i,
  input  wire xlen_t   quot_i,
  input  wire xlen_t   rem_i,
  output xlen_t        result_o
);

  div_op_t op_q;
  logic    neg_q_q;
  logic    neg_r_q;
  logic    is_rem;
  logic    is_word;
  xlen_t   q_fix;
  xlen_t   r_fix;
  xlen_t   sel;

  // operation context, held for the whole division
  always_ff @(posedge clk) begin
    if (rst_n) begin
      op_q    <= '0;
      neg_q_q <= 1'b0;
      neg_r_q <= 1'b0;
    end else if (load_i) begin
      op_q    <= op_i;
      neg_q_q <= neg_q_i;
      neg_r_q <= neg_r_i;
    end
  end

  assign is_rem  = |(op_q & OP_REM_M);
  assign is_word = |(op_q & OP_WORD_M);

  // sign restore
  assign q_fix = neg_q_q ? (~quot_i + 64'd1) : quot_i;
  assign r_fix = neg_r_q ? (~rem_i + 64'd1) : rem_i;
  assign sel   = is_rem ? r_fix : q_fix;

  // result register, stable until the next load
  always_ff @(posedge clk) begin
    if (exc_load_i) begin
      result_o <= exc_value_i;      // already architectural
    end else if (capture_i) begin
      result_o <= is_word ? {{32{sel[31]}}, sel[31:0]} : sel;
    end
  end

endmodule

`default_nettype wire

// File: hdl/div_unit.sv
// iterative integer divide unit
`timescale 1ns/10ps
`default_nettype none

module div_unit
  import div_pkg::*;
#(
  parameter int unsigned RSP_CREDITS = 2
) (
  input  wire logic    clk,
  input  wire logic    rst_n,
  input  wire logic    req_valid_i,
  input  wire div_op_t req_op_i,
  input  wire xlen_t   req_a_i,
  input  wire xlen_t   req_b_i,
  input  wire logic    credit_i,
  output logic         busy_o,
  output logic         rsp_valid_o,
  output xlen_t        rsp_data_o
);

  xlen_t mag_a;
  xlen_t mag_b;
  xlen_t exc_value;
  xlen_t quot;
  xlen_t rem;
  logic  neg_q;
  logic  neg_r;
  logic  is_word;
  logic  exc;
  logic  load;
  logic  exc_load;
  logic  step;
  logic  capture;
  logic  done;

  div_precheck u_precheck (
    .op_i        (req_op_i),
    .a_i         (req_a_i),
    .b_i         (req_b_i),
    .mag_a_o     (mag_a),
    .mag_b_o     (mag_b),
    .neg_q_o     (neg_q),
    .neg_r_o     (neg_r),
    .is_word_o   (is_word),
    .exc_o       (exc),
    .exc_value_o (exc_value)
  );

  div_iter_core u_iter (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_i     (load),
    .step_i     (step),
    .is_word_i  (is_word),
    .dividend_i (mag_a),
    .divisor_i  (mag_b),
    .quot_o     (quot),
    .rem_o      (rem),
    .done_o     (done)
  );

  div_result_fix u_fix (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_i      (load),
    .exc_load_i  (exc_load),
    .capture_i   (capture),
    .op_i        (req_op_i),
    .neg_q_i     (neg_q),
    .neg_r_i     (neg_r),
    .exc_value_i (exc_value),
    .quot_i      (quot),
    .rem_i       (rem),
    .result_o    (rsp_data_o)
  );

  div_ctrl #(
    .RSP_CREDITS (RSP_CREDITS)
  ) u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .exc_i       (exc),
    .done_i      (done),
    .credit_i    (credit_i),
    .load_o      (load),
    .exc_load_o  (exc_load),
    .step_o      (step),
    .capture_o   (capture),
    .busy_o      (busy_o),
    .rsp_valid_o (rsp_valid_o)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the divide unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f div_unit.f --top-module tb_div_unit -o tb_div_unit

out="$(./obj_dir/tb_div_unit)"
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1

// File: sim/tb_div_model.svh
// divide reference model
`ifndef TB_DIV_MODEL_SVH
`define TB_DIV_MODEL_SVH

// architectural result of one M-extension divide operation
function automatic xlen_t div_model(input div_op_t op, input xlen_t a, input xlen_t b);
  logic signed [63:0] sa;
  logic signed [63:0] sb;
  logic signed [31:0] wa;
  logic signed [31:0] wb;
  logic [31:0]        w;
  logic               min64;
  logic               min32;
  logic               is_w;
  xlen_t              r;
  sa    = a;
  sb    = b;
  wa    = a[31:0];
  wb    = b[31:0];
  min64 = (a == {1'b1, 63'b0}) && (b == '1);                          // -2^63 / -1
  min32 = (a[31:0] == 32'h8000_0000) && (b[31:0] == 32'hffff_ffff);
  is_w  = op inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
  w     = '0;
  r     = '0;
  case (op)
    OP_DIV:   if (b == '0) r = '1; else if (min64) r = a; else r = sa / sb;
    OP_DIVU:  if (b == '0) r = '1; else r = a / b;
    OP_REM:   if (b == '0) r = a; else if (min64) r = '0; else r = sa % sb;
    OP_REMU:  if (b == '0) r = a; else r = a % b;
    OP_DIVW:  if (wb == 0) w = '1; else if (min32) w = wa; else w = wa / wb;
    OP_DIVUW: if (b[31:0] == '0) w = '1; else w = a[31:0] / b[31:0];
    OP_REMW:  if (wb == 0) w = wa; else if (min32) w = '0; else w = wa % wb;
    OP_REMUW: if (b[31:0] == '0) w = a[31:0]; else w = a[31:0] % b[31:0];
    default:  r = 'x;                      // not one-hot
  endcase
  if (is_w) begin
    r = {{32{w[31]}}, w};                  // word results are sign-extended
  end
  return r;
endfunction

// fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

// File: sim/tb_div_unit.sv
// divide unit testbench
`timescale 1ns/10ps
`default_nettype none

module tb_div_unit
  import div_pkg::*;
();

  localparam int unsigned RSP_CREDITS = 2;
  localparam int          WAIT_LIMIT  = 400;   // cycles per wait loop

  logic    clk;
  logic    rst_n;
  logic    req_valid_i;
  div_op_t req_op_i;
  xlen_t   req_a_i;
  xlen_t   req_b_i;
  logic    credit_i = 1'b0;
  logic    busy_o;
  logic    rsp_valid_o;
  xlen_t   rsp_data_o;

  xlen_t       exp_q[$];                       // expected responses in request order
  string       tag_q[$];
  int          ret_q[$];                       // cycle at which a slot goes back
  int          cycle;
  int          errors;
  int          err_mark;
  int          tests;
  int          accepted;
  int          received;
  int          returned;
  int          credit_delay;
  int          release_cnt;
  logic        hold_credits;
  logic [31:0] lfsr_state;

  `include "tb_div_model.svh"

  div_unit #(
    .RSP_CREDITS (RSP_CREDITS)
  ) dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_op_i    (req_op_i),
    .req_a_i     (req_a_i),
    .req_b_i     (req_b_i),
    .credit_i    (credit_i),
    .busy_o      (busy_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_data_o  (rsp_data_o)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // ==========================================================================
  // compare and helper tasks
  // ==========================================================================
  task automatic check_result(input xlen_t got, input xlen_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Fail @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_credit(input credit_t got, input credit_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Fail @ %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic abort(input string why);
    $display("Timeout @ %0t ns: %s", $time, why);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  function automatic xlen_t rand_bits(input int n);
    xlen_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};        // one step per bit
    end
    return v;
  endfunction

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy_o) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) abort("busy_o stayed high, the unit never became free");
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) abort("a request never got its response");
    end
  endtask

  task automatic wait_credits_home();
    int n;
    n = 0;
    while (ret_q.size() != 0) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) abort("the consumer never returned its slots");
    end
  endtask

  // called on a falling edge and returns on the one after the accept
  task automatic send(input div_op_t op, input xlen_t a, input xlen_t b);
    wait_idle();
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_a_i     = a;
    req_b_i     = b;
    exp_q.push_back(div_model(op, a, b));
    tag_q.push_back($sformatf("op %b a %h b %h", op, a, b));
    @(negedge clk);
    req_valid_i = 1'b0;
    accepted++;
  endtask

  task automatic send_ops(input div_op_t mask, input xlen_t a, input xlen_t b);
    for (int i = 7; i >= 0; i--) begin
      if (mask[i]) send(div_op_t'(8'd1 << i), a, b);
    end
  endtask

  task automatic end_test(input string name);
    wait_drain();
    tests++;
    if (errors == err_mark) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  // ==========================================================================
  // checker and credit-returning consumer
  // ==========================================================================
  always @(negedge clk) begin
    credit_i = 1'b0;
    if (!rst_n) begin
      cycle++;
      if (rsp_valid_o) begin
        received++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Error @ %0t ns: a response came with no request pending", $time);
        end else begin
          check_result(rsp_data_o, exp_q.pop_front(), tag_q.pop_front());
        end
        ret_q.push_back(cycle + credit_delay);
        if (received - returned > int'(RSP_CREDITS)) begin
          errors++;
          $display("Error @ %0t ns: more responses out than the consumer has slots", $time);
        end
      end
      if (!busy_o && accepted > received) begin
        errors++;
        $display("Fail @ %0t ns: busy_o low while a response is still pending", $time);
      end
      // one slot back per cycle once its delay is over
      if (ret_q.size() != 0 && ret_q[0] <= cycle && (!hold_credits || release_cnt > 0)) begin
        void'(ret_q.pop_front());
        credit_i = 1'b1;
        returned++;
        if (hold_credits) release_cnt--;
      end
    end
  end

  // ==========================================================================
  // stimulus
  // ==========================================================================
  initial begin
    div_op_t op;
    xlen_t   a;
    xlen_t   b;
    xlen_t   held;
    int      base;
    rst_n        = 1'b1;                   // active high
    req_valid_i  = 1'b0;
    req_op_i     = '0;
    req_a_i      = '0;
    req_b_i      = '0;
    cycle        = 0;
    errors       = 0;
    err_mark     = 0;
    tests        = 0;
    accepted     = 0;
    received     = 0;
    returned     = 0;
    release_cnt  = 0;
    credit_delay = 3;
    hold_credits = 1'b0;
    lfsr_state   = 32'he2d6;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b0;
    if (busy_o !== 1'b0 || rsp_valid_o !== 1'b0) begin
      errors++;
      $display("Fail @ %0t ns: busy_o or rsp_valid_o not low after reset", $time);
    end

    send_ops(OP_DIVU | OP_REMU, 64'hffff_ffff_ffff_ffff, 64'd3);
    send_ops(OP_DIVU | OP_REMU, 64'h0123_4567_89ab_cdef, 64'd10);
    send_ops(OP_DIVU | OP_REMU, 64'd5, 64'hffff_0000_0000_0000);
    send_ops(OP_DIVU | OP_REMU, 64'hdead_beef_cafe_f00d, 64'd1);
    send_ops(OP_DIVU | OP_REMU, 64'hffff_ffff_ffff_fffe, 64'hffff_ffff_ffff_ffff);
    end_test("unsigned 64-bit");

    send_ops(OP_DIV | OP_REM, 64'd100, 64'd7);
    send_ops(OP_DIV | OP_REM, 64'hffff_ffff_ffff_ff9c, 64'd7);
    send_ops(OP_DIV | OP_REM, 64'd100, 64'hffff_ffff_ffff_fff9);
    send_ops(OP_DIV | OP_REM, 64'hffff_ffff_ffff_ff9c, 64'hffff_ffff_ffff_fff9);
    send_ops(OP_DIV | OP_REM, 64'h8000_0000_0000_0001, 64'd3);
    send_ops(OP_DIV | OP_REM, 64'hffff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_ffff);
    end_test("signed 64-bit");

    // junk in the upper halves
    send_ops(OP_WORD_M, 64'hdead_beef_ffff_ff9c, 64'h1234_5678_0000_0007);
    send_ops(OP_WORD_M, 64'h0bad_f00d_0000_0064, 64'hffff_0000_ffff_fff9);
    send_ops(OP_WORD_M, 64'hffff_ffff_9abc_def0, 64'h0000_0000_0001_0003);
    send_ops(OP_WORD_M, 64'h7777_0000_ffff_ffff, 64'h8888_1111_0000_0001);
    end_test("word ops");

    send_ops(8'hff, 64'h0123_4567_89ab_cdef, 64'h0);
    send_ops(8'hff, 64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff);
    send_ops(8'hff, 64'h5555_5555_8000_0000, 64'h0000_0001_ffff_ffff);
    send_ops(8'hff, 64'h1234_5678_8765_4321, 64'hffff_0000_0000_0000);
    end_test("special cases");

    // slots held back so the third response finds none
    wait_credits_home();
    hold_credits = 1'b1;
    release_cnt  = 0;
    base         = received;
    send(OP_DIVU, 64'd1000, 64'd7);
    send(OP_REM, 64'hffff_ffff_ffff_fc18, 64'd33);
    send(OP_DIV, 64'h7fff_ffff_ffff_ffff, 64'd5);
    repeat (80) @(negedge clk);
    held = rsp_data_o;
    check_result(held, exp_q[0], "held response data");
    repeat (40) @(negedge clk);
    check_result(rsp_data_o, held, "data while stalled");
    check_credit(credit_t'(received - base), credit_t'(RSP_CREDITS), "responses without credit");
    if (!busy_o) begin
      errors++;
      $display("Fail @ %0t ns: busy_o dropped while the response was stalled", $time);
    end
    // a single returned slot lets one response out and the next one stalls
    release_cnt = 1;
    send(OP_REMU, 64'h0000_0000_0001_86a0, 64'd9);
    repeat (80) @(negedge clk);
    check_result(rsp_data_o, exp_q[0], "second held response data");
    check_credit(credit_t'(received - base), credit_t'(RSP_CREDITS + 1),
                 "responses after one credit");
    if (!busy_o) begin
      errors++;
      $display("Fail @ %0t ns: busy_o dropped while the next response was stalled", $time);
    end
    hold_credits = 1'b0;
    end_test("back-pressure");

    for (int i = 0; i < 300; i++) begin
      op = div_op_t'(8'd1 << rand_bits(3));
      a  = rand_bits(64);
      b  = rand_bits(64);
      case (rand_bits(3))
        0: b = '0;
        1: b = b >> rand_bits(6);              // short divisors
        2: begin
          a = {a[63:32], 32'h8000_0000};
          b = {b[63:32], 32'hffff_ffff};
        end
        3: begin
          a = 64'h8000_0000_0000_0000;
          b = '1;
        end
        default: ;
      endcase
      credit_delay = int'(rand_bits(3));
      send(op, a, b);
    end
    end_test("random");

    wait_credits_home();
    $display("%0d tests, %0d responses, %0d errors", tests, received, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
